// ==== list.f ====
+incdir+testbench
common/mandel_pkg.sv
common/point_if.sv
common/result_if.sv
rtl/pixel_walker.sv
escape_iterator/escape_iterator.sv
rtl/pixel_writer.sv
rtl/mandel_top.sv
testbench/tb_mandel.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mandel
FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat list.f)) $(wildcard testbench/*.svh)
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f list.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== testbench/tb_checks.svh ====
//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_addr(input string name, input addr_t got, input addr_t want);
	if (got !== want) begin
		$display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
		abort_run();
	end
endtask

task automatic check_color(input string name, input color_t got, input color_t want);
	if (got !== want) begin
		$display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
		abort_run();
	end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
	if (got !== want) begin
		$display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
		abort_run();
	end
endtask

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Escape count of one pixel and its band colour
task automatic model_pixel(input coord_t x0, input coord_t y0, input coord_t stp,
	input int index, output color_t color);
	coord_t col;
	coord_t row;
	coord_t c_re;
	coord_t c_im;
	coord_t zr;
	coord_t zi;
	coord_t zr_sq;
	coord_t zi_sq;
	coord_t zr_zi;
	coord_t zr_n;
	coord_t zi_n;
	coord_t mag;
	count_t count;
	logic [3:0] band;
	logic stop;
	col = coord_t'(index % H_PIXELS);
	row = coord_t'(index / H_PIXELS);
	// Wrapping 27-bit plane position
	c_re = x0 + col * stp;
	c_im = y0 - row * stp;
	zr = '0;
	zi = '0;
	count = '0;
	stop = 1'b0;
	while (!stop) begin
		zr_sq = fx_mult(zr, zr);
		zi_sq = fx_mult(zi, zi);
		zr_zi = fx_mult(zr, zi);
		zr_n = zr_sq - zi_sq + c_re;
		zi_n = zr_zi + zr_zi + c_im;
		mag = zr_sq + zi_sq;
		count = count + 1'b1;
		stop = (mag > ESCAPE_MAG) || (zr_n > ESCAPE_COORD) || (zr_n < -ESCAPE_COORD)
			|| (zi_n > ESCAPE_COORD) || (zi_n < -ESCAPE_COORD)
			|| (count == count_t'(ITER_MAX));
		zr = zr_n;
		zi = zi_n;
	end
	// Walk bands up until the count clears the threshold
	if (count == count_t'(ITER_MAX))
		band = 4'd0;
	else begin
		band = 4'd1;
		while (band < 4'd8 && count < count_t'(ITER_MAX >> band))
			band = band + 1'b1;
	end
	color = PALETTE[band];
endtask

//////////////////////////////////////////////////
// Frame driver
//////////////////////////////////////////////////

// One frame from start pulse to frame_done with checks every cycle
task automatic run_frame(input coord_t x0, input coord_t y0, input coord_t stp,
	input logic random_ready, input logic poke_start);
	int sent;
	logic finished;
	logic poked;
	logic was_stall;
	logic was_last;
	addr_t held_addr;
	color_t held_color;
	color_t want;
	got_colors.delete();
	sent = 0;
	finished = 1'b0;
	poked = 1'b0;
	was_stall = 1'b0;
	was_last = 1'b0;
	held_addr = '0;
	held_color = '0;
	start = 1'b1;
	x_start = x0;
	y_start = y0;
	step = stp;
	@(negedge clk);
	start = 1'b0;
	check_flag("busy", busy, 1'b1);
	while (!finished) begin
		// Outcome of the last rising edge
		if (was_stall) begin
			check_flag("pix_valid", pix_valid, 1'b1);
			check_addr("pix_addr", pix_addr, held_addr);
			check_color("pix_color", pix_color, held_color);
		end
		check_flag("frame_done", frame_done, was_last);
		check_flag("busy", busy, !was_last);
		if (was_last)
			finished = 1'b1;
		else begin
			// Stray start a quarter into the frame
			start = poke_start && !poked && (sent == PIXELS / 4);
			if (start) begin
				x_start = ~x0;
				poked = 1'b1;
			end
			pix_ready = random_ready ? 1'($random(seed)) : 1'b1;
			was_stall = pix_valid && !pix_ready;
			held_addr = pix_addr;
			held_color = pix_color;
			if (pix_valid && pix_ready) begin
				check_addr("pix_addr", pix_addr, addr_t'(sent));
				model_pixel(x0, y0, stp, sent, want);
				check_color("pix_color", pix_color, want);
				got_colors.push_back(pix_color);
				was_last = (sent == PIXELS - 1);
				sent++;
			end
			@(negedge clk);
		end
	end
	start = 1'b0;
	pix_ready = 1'b1;
	// No second frame afterwards
	repeat (5) begin
		@(negedge clk);
		check_flag("pix_valid", pix_valid, 1'b0);
		check_flag("busy", busy, 1'b0);
		check_flag("frame_done", frame_done, 1'b0);
	end
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic idle_after_reset();
	repeat (20) begin
		check_flag("pix_valid", pix_valid, 1'b0);
		check_flag("busy", busy, 1'b0);
		check_flag("frame_done", frame_done, 1'b0);
		check_flag("point valid", mandel_inst.point_bus.valid, 1'b0);
		check_flag("result valid", mandel_inst.result_bus.valid, 1'b0);
		@(negedge clk);
	end
endtask

task automatic plain_frame();
	run_frame(WIDE_X, WIDE_Y, WIDE_STEP, 1'b0, 1'b0);
endtask

// Same picture under random back-pressure
task automatic backpressure_frame();
	run_frame(WIDE_X, WIDE_Y, WIDE_STEP, 1'b1, 1'b0);
endtask

task automatic ignored_start_frame();
	run_frame(WIDE_X, WIDE_Y, WIDE_STEP, 1'b0, 1'b1);
endtask

// Whole window inside the set so the iteration limit is reached
task automatic inside_set_frame();
	run_frame(NEAR_X, NEAR_Y, NEAR_STEP, 1'b0, 1'b0);
	// Black in RGB332
	check_color("centre pix_color", got_colors[CENTRE], color_t'(8'h00));
endtask

// ==== testbench/tb_mandel.sv ====
`timescale 1ns/1ps

module tb_mandel import mandel_pkg::*; ();
	localparam int H_PIXELS = 8;
	localparam int V_PIXELS = 6;
	localparam int ITER_MAX = 64;
	localparam int PIXELS = H_PIXELS * V_PIXELS;
	// Five frames at worst latency with margin for back-pressure
	localparam int TIMEOUT_CYCLES = 5 * PIXELS * (ITER_MAX + 4) * 3;

	// Whole set in view from -2.0/1.0 in steps of 0.375
	localparam coord_t WIDE_X = coord_t'(-2 * (1 << FRAC_BITS));
	localparam coord_t WIDE_Y = coord_t'(1 << FRAC_BITS);
	localparam coord_t WIDE_STEP = coord_t'(3 << (FRAC_BITS - 3));
	// Small window inside the main cardioid with step 2^-6
	localparam coord_t NEAR_X = coord_t'(-(1 << (FRAC_BITS - 2)));
	localparam coord_t NEAR_Y = coord_t'(1 << (FRAC_BITS - 2));
	localparam coord_t NEAR_STEP = coord_t'(1 << (FRAC_BITS - 6));
	// Middle pixel of the frame
	localparam int CENTRE = (V_PIXELS / 2) * H_PIXELS + H_PIXELS / 2;

	logic clk;
	logic reset;
	logic start;
	coord_t x_start;
	coord_t y_start;
	coord_t step;
	logic pix_ready;
	logic pix_valid;
	addr_t pix_addr;
	color_t pix_color;
	logic busy;
	logic frame_done;

	integer seed;
	int cycles = 0;
	// Colours of the last frame
	color_t got_colors [$];

	mandel_top #(
		.H_PIXELS(H_PIXELS),
		.V_PIXELS(V_PIXELS),
		.ITER_MAX(ITER_MAX)
	) mandel_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.step(step),
		.pix_ready(pix_ready),
		.pix_valid(pix_valid),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.busy(busy),
		.frame_done(frame_done)
	);

	// Stop on the first error
	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	`include "tb_checks.svh"

	//////////////////////////////////////////////////
	// Clock and watchdog
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the frame never finished", cycles);
			abort_run();
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		seed = 88;
		reset = 1'b1;
		start = 1'b0;
		x_start = '0;
		y_start = '0;
		step = '0;
		pix_ready = 1'b1;
		// Eight rising edges in reset
		repeat (8) @(negedge clk);
		reset = 1'b0;

		idle_after_reset();
		plain_frame();
		backpressure_frame();
		ignored_start_frame();
		inside_set_frame();

		$display("test passed");
		$finish;
	end

endmodule

// ==== rtl/mandel_top.sv ====
`timescale 1ns/1ps

module mandel_top import mandel_pkg::*; #(
	parameter int H_PIXELS = 640,
	parameter int V_PIXELS = 480,
	parameter int ITER_MAX = 1000
) (
	input logic clk,
	input logic reset,
	input logic start,
	input coord_t x_start,
	input coord_t y_start,
	input coord_t step,
	input logic pix_ready,
	output logic pix_valid,
	output addr_t pix_addr,
	output color_t pix_color,
	output logic busy,
	output logic frame_done
);
	// Writer tells walker the frame is out
	logic last_written;

	point_if point_bus ();
	result_if result_bus ();

	// Raster walk, one point at a time
	pixel_walker #(
		.H_PIXELS(H_PIXELS),
		.V_PIXELS(V_PIXELS)
	) walker_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.step(step),
		.last_written(last_written),
		.busy(busy),
		.frame_done(frame_done),
		.point(point_bus)
	);

	// Single escape-time engine
	escape_iterator #(
		.ITER_MAX(ITER_MAX)
	) iterator_inst (
		.clk(clk),
		.reset(reset),
		.point(point_bus),
		.result(result_bus)
	);

	// Colour and pixel stream
	pixel_writer #(
		.H_PIXELS(H_PIXELS),
		.V_PIXELS(V_PIXELS),
		.ITER_MAX(ITER_MAX)
	) writer_inst (
		.clk(clk),
		.reset(reset),
		.pix_ready(pix_ready),
		.result(result_bus),
		.pix_valid(pix_valid),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.last_written(last_written)
	);

endmodule

// ==== rtl/pixel_writer.sv ====
`timescale 1ns/1ps

module pixel_writer import mandel_pkg::*; #(
	parameter int H_PIXELS = 640,
	parameter int V_PIXELS = 480,
	parameter int ITER_MAX = 1000
) (
	input logic clk,
	input logic reset,
	input logic pix_ready,
	result_if.writer result,
	output logic pix_valid,
	output addr_t pix_addr,
	output color_t pix_color,
	output logic last_written
);
	localparam addr_t LAST_ADDR = addr_t'(H_PIXELS * V_PIXELS - 1);

	logic [3:0] band;
	logic accept;

	//////////////////////////////////////////////////
	// Count to colour band
	//////////////////////////////////////////////////

	// Smallest k with count >= ITER_MAX >> k, else band 8
	always_comb begin
		band = 4'd8;
		for (int k = 8; k >= 1; k--) begin
			if (result.count >= count_t'(ITER_MAX >> k))
				band = 4'(k);
		end
		// Never escaped
		if (result.count == count_t'(ITER_MAX))
			band = 4'd0;
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	// Free slot, or the held pixel leaves this cycle
	assign result.ready = !pix_valid || pix_ready;
	assign accept = result.valid && result.ready;

	always_ff @(posedge clk) begin
		if (reset)
			pix_valid <= 1'b0;
		else if (accept)
			pix_valid <= 1'b1;
		else if (pix_ready)
			pix_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pix_addr <= result.addr;
			pix_color <= PALETTE[band];
		end
	end

	// Final pixel of the frame on its way out
	assign last_written = pix_valid && pix_ready && (pix_addr == LAST_ADDR);

	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_addr) && $stable(pix_color));

endmodule

// ==== escape_iterator/escape_iterator.sv ====
`timescale 1ns/1ps

module escape_iterator import mandel_pkg::*; #(
	parameter int ITER_MAX = 1000
) (
	input logic clk,
	input logic reset,
	point_if.iterator point,
	result_if.iterator result
);
	iter_state_t state;

	// Point under test
	coord_t c_re;
	coord_t c_im;
	addr_t addr;

	// Current z and running count
	coord_t zr;
	coord_t zi;
	count_t count;

	// Per-iteration terms
	coord_t zr_sq;
	coord_t zi_sq;
	coord_t zr_zi;
	coord_t zr_next;
	coord_t zi_next;
	coord_t mag_sq;
	count_t count_next;
	logic escaped;
	logic at_limit;

	//////////////////////////////////////////////////
	// Datapath, three multipliers on current z
	//////////////////////////////////////////////////

	assign zr_sq = fx_mult(zr, zr);
	assign zi_sq = fx_mult(zi, zi);
	assign zr_zi = fx_mult(zr, zi);

	// z*z + c
	assign zr_next = zr_sq - zi_sq + c_re;
	assign zi_next = (zr_zi <<< 1) + c_im;
	assign mag_sq = zr_sq + zi_sq;
	assign count_next = count + 1'b1;

	// Out of the radius-2 disc, or a component past 2
	assign escaped = (mag_sq > ESCAPE_MAG)
		|| (zr_next > ESCAPE_COORD) || (zr_next < -ESCAPE_COORD)
		|| (zi_next > ESCAPE_COORD) || (zi_next < -ESCAPE_COORD);
	assign at_limit = (count_next == count_t'(ITER_MAX));

	//////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////

	assign point.ready = (state == ITER_IDLE);
	assign result.valid = (state == ITER_DONE);
	assign result.count = count;
	assign result.addr = addr;

	always_ff @(posedge clk) begin
		if (reset)
			state <= ITER_IDLE;
		else begin
			case (state)
				ITER_IDLE:
					if (point.valid)
						state <= ITER_CALC;
				ITER_CALC:
					if (escaped || at_limit)
						state <= ITER_DONE;
				ITER_DONE:
					// Hold result until writer takes it
					if (result.ready)
						state <= ITER_IDLE;
				default:
					state <= ITER_IDLE;
			endcase
		end
	end

	// Point capture and z update
	always_ff @(posedge clk) begin
		if (state == ITER_IDLE && point.valid) begin
			c_re <= point.c_re;
			c_im <= point.c_im;
			addr <= point.addr;
			zr <= '0;
			zi <= '0;
			count <= '0;
		end else if (state == ITER_CALC) begin
			zr <= zr_next;
			zi <= zi_next;
			count <= count_next;
		end
	end

	// Offered result held until taken
	a_result_hold: assert property (@(posedge clk) disable iff (reset)
		result.valid && !result.ready |=> result.valid && $stable(result.count));

endmodule

// ==== rtl/pixel_walker.sv ====
`timescale 1ns/1ps

module pixel_walker import mandel_pkg::*; #(
	parameter int H_PIXELS = 640,
	parameter int V_PIXELS = 480
) (
	input logic clk,
	input logic reset,
	input logic start,
	input coord_t x_start,
	input coord_t y_start,
	input coord_t step,
	input logic last_written,
	output logic busy,
	output logic frame_done,
	point_if.walker point
);
	localparam int PIXELS = H_PIXELS * V_PIXELS;
	localparam int COL_W = $clog2(H_PIXELS + 1);
	localparam int ROW_W = $clog2(V_PIXELS + 1);

	frame_state_t state;
	coord_t x_origin;
	coord_t x_step;
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic launch;
	logic taken;
	logic row_end;
	logic frame_end;

	assign launch = (state == FRAME_IDLE) && start;
	assign taken = point.valid && point.ready;
	assign row_end = (col == COL_W'(H_PIXELS - 1));
	assign frame_end = row_end && (row == ROW_W'(V_PIXELS - 1));
	assign busy = (state == FRAME_RUN);

	//////////////////////////////////////////////////
	// Frame control and raster position
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FRAME_IDLE;
			point.valid <= 1'b0;
			frame_done <= 1'b0;
			col <= '0;
			row <= '0;
		end else begin
			frame_done <= 1'b0;
			if (launch) begin
				state <= FRAME_RUN;
				point.valid <= 1'b1;
				col <= '0;
				row <= '0;
			end else if (state == FRAME_RUN) begin
				// Last point gone, nothing more to offer
				if (taken && frame_end)
					point.valid <= 1'b0;
				else if (taken && row_end) begin
					col <= '0;
					row <= row + 1'b1;
				end else if (taken)
					col <= col + 1'b1;
				// Frame ends once the final pixel leaves the writer
				if (last_written) begin
					state <= FRAME_IDLE;
					frame_done <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Plane coordinates
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (launch) begin
			x_origin <= x_start;
			x_step <= step;
			point.c_re <= x_start;
			point.c_im <= y_start;
			point.addr <= '0;
		end else if (taken && !frame_end) begin
			point.addr <= point.addr + 1'b1;
			// Back to left edge, one row down
			if (row_end) begin
				point.c_re <= x_origin;
				point.c_im <= point.c_im - x_step;
			end else
				point.c_re <= point.c_re + x_step;
		end
	end

	// Offered address stays inside the frame
	a_addr_range: assert property (@(posedge clk) disable iff (reset)
		point.valid |-> point.addr < addr_t'(PIXELS));

endmodule

// ==== common/result_if.sv ====
`timescale 1ns/1ps

// Iteration count for one pixel
interface result_if import mandel_pkg::*; ();
	logic valid;
	logic ready;
	count_t count;
	addr_t addr;

	modport iterator (
		output valid,
		output count,
		output addr,
		input ready
	);

	// Writer side takes results
	modport writer (
		input valid,
		input count,
		input addr,
		output ready
	);
endinterface

// ==== common/point_if.sv ====
`timescale 1ns/1ps

// One plane point and its pixel address
interface point_if import mandel_pkg::*; ();
	logic valid;
	logic ready;
	coord_t c_re;
	coord_t c_im;
	addr_t addr;

	// Walker side offers points
	modport walker (
		output valid,
		output c_re,
		output c_im,
		output addr,
		input ready
	);

	modport iterator (
		input valid,
		input c_re,
		input c_im,
		input addr,
		output ready
	);
endinterface

// ==== common/mandel_pkg.sv ====
package mandel_pkg;

	//////////////////////////////////////////////////
	// Fixed point format, signed 4.23
	//////////////////////////////////////////////////

	localparam int FRAC_BITS = 23;

	typedef logic signed [26:0] coord_t;

	// Pixel address, enough for 640x480
	localparam int ADDR_W = 19;
	typedef logic [ADDR_W-1:0] addr_t;

	// Iteration count, limits up to 1024
	localparam int CNT_W = 11;
	typedef logic [CNT_W-1:0] count_t;

	// RGB332, red on top and blue in the low two bits
	typedef logic [7:0] color_t;

	// Escape bounds
	localparam coord_t ESCAPE_MAG = 27'sh2000000;
	localparam coord_t ESCAPE_COORD = 27'sh1000000;

	// One colour per band, band 0 is inside the set
	localparam color_t PALETTE [0:8] = '{
		8'b000_000_00,
		8'b011_001_00,
		8'b011_001_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_01,
		8'b011_010_10,
		8'b010_100_10,
		8'b010_100_10
	};

	typedef enum logic [1:0] {ITER_IDLE, ITER_CALC, ITER_DONE} iter_state_t;
	typedef enum logic {FRAME_IDLE, FRAME_RUN} frame_state_t;

	// Full product, then sign plus bits 48..23
	function automatic coord_t fx_mult(input coord_t a, input coord_t b);
		logic signed [53:0] prod;
		prod = a * b;
		return {prod[53], prod[48:FRAC_BITS]};
	endfunction

endpackage
